/* cache_params.svh */
/* data cache geometry and memory timing
   shared by the cache, the memory controller and the word memory */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// associativity
`define DC_WAYS 2

// sets in the cache
`define DC_SETS 8

// words in one block
`define DC_BLK_WORDS 2

// 32 - 3 index bits - 1 block offset bit - 2 byte offset bits
`define DC_TAG_W 26

// main memory depth in words
`define MEM_WORDS 4096

// dwait cycles per memory access
`define MEM_LAT 2

// the hit count lands here once the flush is done
`define HIT_CNT_ADDR 32'h00003100

`endif

/* cache_pkg.sv */
/* data cache shared types
   word, address fields and the controller states */
`include "cache_params.svh"

package cache_pkg;

    // one data word, also the address width
    typedef logic [31:0] word_t;

    // address as the cache sees it
    typedef struct packed {
        logic [`DC_TAG_W-1:0]             tag;
        logic [$clog2(`DC_SETS)-1:0]      idx;
        logic [$clog2(`DC_BLK_WORDS)-1:0] blkoff;
        logic [1:0]                       bytoff;  // always zero, word access only
    } dcache_addr_t;

    // controller states
    typedef enum logic [3:0] {
        IDLE,    // hits, miss detection, halt
        WB1,     // victim word 0 back to memory
        WB2,     // victim word 1 back to memory
        RD1,     // refill word 0
        RD2,     // refill word 1
        FLCHK,   // flush scan, look at one frame
        FL1,     // flush word 0
        FL2,     // flush word 1
        CNTW,    // hit count out to memory
        HALTED   // flushed, stays here
    } dcache_state_t;

endpackage

/* dcache.sv */
/* write-back data cache, 2-way LRU, 2-word blocks
   hits in one cycle, misses write back and refill, snoops and halt flush */
`include "cache_params.svh"

module dcache (
    input  logic             CLK,
    input  logic             nRST,
    // datapath side
    input  logic             dmemREN,
    input  logic             dmemWEN,
    input  logic             halt,
    input  cache_pkg::word_t dmemaddr,
    input  cache_pkg::word_t dmemstore,
    output logic             dhit,
    output logic             flushed,
    output cache_pkg::word_t dmemload,
    // memory controller side
    input  logic             dwait,
    input  logic             ccwait,
    input  logic             ccinv,
    input  cache_pkg::word_t dload,
    input  cache_pkg::word_t ccsnoopaddr,
    output logic             dREN,
    output logic             dWEN,
    output logic             ccwrite,
    output logic             cctrans,
    output cache_pkg::word_t daddr,
    output cache_pkg::word_t dstore
);

    localparam int IDX_W = $clog2(`DC_SETS);
    localparam logic [3:0] LAST_ROW = 4'(`DC_SETS * `DC_WAYS - 1);

    typedef struct packed {
        logic                                    valid;
        logic                                    dirty;
        logic [`DC_TAG_W-1:0]                    tag;
        cache_pkg::word_t [`DC_BLK_WORDS-1:0]    data;
    } frame_t;

    typedef struct packed {
        frame_t [`DC_WAYS-1:0] frm;
        logic                  lru;  // way to replace next
    } set_t;

    set_t [`DC_SETS-1:0] sets, nxt_sets;

    cache_pkg::dcache_state_t state, nxt_state;
    cache_pkg::dcache_addr_t  req_a, snp_a;
    cache_pkg::word_t         hit_cnt, nxt_hit_cnt;

    logic [3:0] row, nxt_row;            // flush walk, {set, way}
    logic       victim, nxt_victim;      // way picked at miss time
    logic       just_filled, nxt_just_filled;
    logic       req_hit, hit_way, pick_way;
    frame_t     vf, ff;

    assign req_a = dmemaddr;
    assign snp_a = ccsnoopaddr;
    assign vf    = sets[req_a.idx].frm[victim];
    assign ff    = sets[row[3:1]].frm[row[0]];

    // an empty way goes first, then the LRU one
    assign pick_way = !sets[req_a.idx].frm[0].valid ? 1'b0 :
                      !sets[req_a.idx].frm[1].valid ? 1'b1 : sets[req_a.idx].lru;

    function automatic cache_pkg::word_t blk_addr(input logic [`DC_TAG_W-1:0] tag,
                                                  input logic [IDX_W-1:0] idx,
                                                  input logic blk);
        cache_pkg::dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = blk;
        a.bytoff = 2'b00;
        return a;
    endfunction

    always_comb begin
        req_hit = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (sets[req_a.idx].frm[w].valid && sets[req_a.idx].frm[w].tag == req_a.tag) begin
                req_hit = 1'b1;
                hit_way = w[0];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= cache_pkg::IDLE;
            sets        <= '0;
            row         <= '0;
            hit_cnt     <= '0;
            victim      <= 1'b0;
            just_filled <= 1'b0;
        end else begin
            state       <= nxt_state;
            sets        <= nxt_sets;
            row         <= nxt_row;
            hit_cnt     <= nxt_hit_cnt;
            victim      <= nxt_victim;
            just_filled <= nxt_just_filled;
        end
    end

    always_comb begin
        nxt_state       = state;
        nxt_sets        = sets;
        nxt_row         = row;
        nxt_hit_cnt     = hit_cnt;
        nxt_victim      = victim;
        nxt_just_filled = just_filled;
        dhit     = 1'b0;
        dmemload = '0;
        flushed  = 1'b0;
        dREN     = 1'b0;
        dWEN     = 1'b0;
        daddr    = '0;
        dstore   = '0;
        ccwrite  = 1'b0;
        cctrans  = 1'b0;

        if (ccwait) begin
            // snoop cycle, the FSM holds
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (sets[snp_a.idx].frm[w].valid &&
                    sets[snp_a.idx].frm[w].tag == snp_a.tag) begin
                    ccwrite = 1'b1;
                    dstore  = sets[snp_a.idx].frm[w].data[snp_a.blkoff];
                    if (ccinv)
                        nxt_sets[snp_a.idx].frm[w].valid = 1'b0;
                    else
                        nxt_sets[snp_a.idx].frm[w].dirty = 1'b0;  // memory gets the copy
                end
            end
        end else begin
            case (state)
                cache_pkg::IDLE: begin
                    if (halt) begin
                        nxt_row   = '0;
                        nxt_state = cache_pkg::FLCHK;
                    end else if ((dmemREN || dmemWEN) && req_hit) begin
                        dhit = 1'b1;
                        nxt_just_filled = 1'b0;
                        nxt_sets[req_a.idx].lru = ~hit_way;
                        if (dmemREN) begin
                            dmemload = sets[req_a.idx].frm[hit_way].data[req_a.blkoff];
                            if (!just_filled)
                                nxt_hit_cnt = hit_cnt + 1'b1;
                        end else begin
                            nxt_sets[req_a.idx].frm[hit_way].data[req_a.blkoff] = dmemstore;
                            nxt_sets[req_a.idx].frm[hit_way].dirty = 1'b1;
                            cctrans = 1'b1;
                            daddr   = dmemaddr;
                        end
                    end else if (dmemREN || dmemWEN) begin
                        nxt_victim = pick_way;
                        if (sets[req_a.idx].frm[pick_way].valid &&
                            sets[req_a.idx].frm[pick_way].dirty)
                            nxt_state = cache_pkg::WB1;
                        else
                            nxt_state = cache_pkg::RD1;
                    end
                end
                cache_pkg::WB1: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(vf.tag, req_a.idx, 1'b0);
                    dstore = vf.data[0];
                    if (!dwait)
                        nxt_state = cache_pkg::WB2;
                end
                cache_pkg::WB2: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(vf.tag, req_a.idx, 1'b1);
                    dstore = vf.data[1];
                    if (!dwait)
                        nxt_state = cache_pkg::RD1;
                end
                cache_pkg::RD1: begin
                    dREN  = 1'b1;
                    daddr = blk_addr(req_a.tag, req_a.idx, 1'b0);
                    if (!dwait) begin
                        // frame half old, half new until RD2, so hide it from snoops
                        nxt_sets[req_a.idx].frm[victim].data[0] = dload;
                        nxt_sets[req_a.idx].frm[victim].valid   = 1'b0;
                        nxt_state = cache_pkg::RD2;
                    end
                end
                cache_pkg::RD2: begin
                    dREN  = 1'b1;
                    daddr = blk_addr(req_a.tag, req_a.idx, 1'b1);
                    if (!dwait) begin
                        nxt_sets[req_a.idx].frm[victim].data[1] = dload;
                        nxt_sets[req_a.idx].frm[victim].tag     = req_a.tag;
                        nxt_sets[req_a.idx].frm[victim].valid   = 1'b1;
                        nxt_sets[req_a.idx].frm[victim].dirty   = 1'b0;
                        nxt_just_filled = 1'b1;
                        nxt_state       = cache_pkg::IDLE;
                    end
                end
                cache_pkg::FLCHK: begin
                    if (ff.valid && ff.dirty)
                        nxt_state = cache_pkg::FL1;
                    else if (row == LAST_ROW)
                        nxt_state = cache_pkg::CNTW;
                    else
                        nxt_row = row + 1'b1;
                end
                cache_pkg::FL1: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(ff.tag, row[3:1], 1'b0);
                    dstore = ff.data[0];
                    if (!dwait)
                        nxt_state = cache_pkg::FL2;
                end
                cache_pkg::FL2: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(ff.tag, row[3:1], 1'b1);
                    dstore = ff.data[1];
                    if (!dwait) begin
                        nxt_sets[row[3:1]].frm[row[0]].dirty = 1'b0;  // FLCHK then moves on
                        nxt_state = cache_pkg::FLCHK;
                    end
                end
                cache_pkg::CNTW: begin
                    dWEN   = 1'b1;
                    daddr  = `HIT_CNT_ADDR;
                    dstore = hit_cnt;
                    if (!dwait)
                        nxt_state = cache_pkg::HALTED;
                end
                cache_pkg::HALTED: flushed = 1'b1;
                default: nxt_state = cache_pkg::IDLE;
            endcase
        end
    end

    a_one_mem_op: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else $error("dREN and dWEN high together");
    a_hit_idle: assert property (@(posedge CLK) disable iff (!nRST)
        dhit |-> state == cache_pkg::IDLE)
        else $error("dhit outside IDLE");
    a_flushed_holds: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else $error("flushed dropped");

endmodule

/* mem_ctrl.sv */
/* memory controller between the data cache and word memory
   outside snoops take priority and stall the cache for one cycle */
module mem_ctrl (
    input  logic             CLK,
    input  logic             nRST,
    // cache side
    input  logic             dREN,
    input  logic             dWEN,
    input  logic             ccwrite,
    input  cache_pkg::word_t daddr,
    input  cache_pkg::word_t dstore,
    output logic             dwait,
    output logic             ccwait,
    output logic             ccinv,
    output cache_pkg::word_t dload,
    output cache_pkg::word_t ccsnoopaddr,
    // outside snoop port
    input  logic             snoop_req,
    input  logic             snoop_inv,
    input  cache_pkg::word_t snoop_addr,
    output logic             snoop_hit,
    output cache_pkg::word_t snoop_data,
    // word memory side
    input  logic             done,
    input  cache_pkg::word_t rdata,
    output logic             req,
    output logic             wen,
    output cache_pkg::word_t addr,
    output cache_pkg::word_t wdata
);

    // a snoop pulls req, so the memory access restarts after it
    assign req   = (dREN || dWEN) && !ccwait;
    assign wen   = dWEN;
    assign addr  = daddr;
    assign wdata = dstore;
    assign dload = rdata;
    assign dwait = !done || ccwait;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ccwait    <= 1'b0;
            ccinv     <= 1'b0;
            snoop_hit <= 1'b0;
        end else begin
            ccwait <= snoop_req && !ccwait;  // one stall cycle per snoop
            if (snoop_req)
                ccinv <= snoop_inv;
            if (ccwait)
                snoop_hit <= ccwrite;        // held until the next snoop
        end
    end

    // snoop address and answer payload
    always_ff @(posedge CLK) begin
        if (snoop_req)
            ccsnoopaddr <= snoop_addr;
        if (ccwait)
            snoop_data <= ccwrite ? dstore : '0;
    end

    a_no_xfer_in_snoop: assert property (@(posedge CLK) disable iff (!nRST) ccwait |-> !done)
        else $error("memory transfer completed during a snoop stall");

endmodule

/* word_ram.sv */
/* main memory of 32-bit words
   cache port with fixed latency, fetch port with one cycle read */
`include "cache_params.svh"

module word_ram (
    input  logic             CLK,
    input  logic             nRST,
    // cache port
    input  logic             req,
    input  logic             wen,
    input  cache_pkg::word_t addr,
    input  cache_pkg::word_t wdata,
    output logic             done,
    output cache_pkg::word_t rdata,
    // fetch port
    input  cache_pkg::word_t fetch_addr,
    output cache_pkg::word_t fetch_data
);

    localparam int AW = $clog2(`MEM_WORDS);
    localparam int CW = $clog2(`MEM_LAT + 1);

    cache_pkg::word_t mem [`MEM_WORDS];
    logic [CW-1:0]    cnt;  // cycles of req so far
    logic [AW-1:0]    widx, fidx;

    assign widx  = addr[AW+1:2];
    assign fidx  = fetch_addr[AW+1:2];
    assign done  = req && (cnt == CW'(`MEM_LAT));
    assign rdata = mem[widx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            cnt <= '0;
        else if (req && !done)
            cnt <= cnt + 1'b1;
        else
            cnt <= '0;  // done or idle, next access starts over
    end

    // every word starts out holding its own byte address
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `MEM_WORDS; i++)
                mem[i] <= cache_pkg::word_t'(i * 4);
        end else if (done && wen) begin
            mem[widx] <= wdata;
        end
    end

    always_ff @(posedge CLK) begin
        fetch_data <= mem[fidx];
    end

    a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        req && !done |=> !req || ($stable(addr) && $stable(wen)))
        else $error("address or write enable changed during an access");

endmodule

/* cache_top.sv */
/* data cache subsystem top
   cache, memory controller and word memory */
module cache_top (
    input  logic             CLK,
    input  logic             nRST,
    // datapath
    input  logic             dmemREN,
    input  logic             dmemWEN,
    input  logic             halt,
    input  cache_pkg::word_t dmemaddr,
    input  cache_pkg::word_t dmemstore,
    output logic             dhit,
    output logic             flushed,
    output cache_pkg::word_t dmemload,
    // snoop port
    input  logic             snoop_req,
    input  logic             snoop_inv,
    input  cache_pkg::word_t snoop_addr,
    output logic             snoop_hit,
    output cache_pkg::word_t snoop_data,
    output logic             cctrans,  // write-hit pulse for the bus
    // instruction fetch
    input  cache_pkg::word_t fetch_addr,
    output cache_pkg::word_t fetch_data
);

    logic             dREN, dWEN, dwait, ccwait, ccinv, ccwrite;
    logic             req, wen, done;
    cache_pkg::word_t daddr, dstore, dload, ccsnoopaddr;
    cache_pkg::word_t addr, wdata, rdata;

    dcache dcache_i (
        .CLK(CLK), .nRST(nRST),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore),
        .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
        .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv),
        .dload(dload), .ccsnoopaddr(ccsnoopaddr),
        .dREN(dREN), .dWEN(dWEN), .ccwrite(ccwrite), .cctrans(cctrans),
        .daddr(daddr), .dstore(dstore)
    );

    mem_ctrl mem_ctrl_i (
        .CLK(CLK), .nRST(nRST),
        .dREN(dREN), .dWEN(dWEN), .ccwrite(ccwrite),
        .daddr(daddr), .dstore(dstore),
        .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv),
        .dload(dload), .ccsnoopaddr(ccsnoopaddr),
        .snoop_req(snoop_req), .snoop_inv(snoop_inv), .snoop_addr(snoop_addr),
        .snoop_hit(snoop_hit), .snoop_data(snoop_data),
        .done(done), .rdata(rdata),
        .req(req), .wen(wen), .addr(addr), .wdata(wdata)
    );

    word_ram word_ram_i (
        .CLK(CLK), .nRST(nRST),
        .req(req), .wen(wen), .addr(addr), .wdata(wdata),
        .done(done), .rdata(rdata),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data)
    );

endmodule

/* tb_cache_top.sv */
/* testbench for the data cache subsystem
   reference cache model, assertion checks on loads, snoops and fetches */
`include "cache_params.svh"

module tb_cache_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW      = $clog2(`MEM_WORDS);
    localparam int IDX_W   = $clog2(`DC_SETS);
    localparam int ACC_CYC = 4 * (`MEM_LAT + 1) + 4;  // write-back, refill, hit and gaps
    localparam int LIMIT   = 250 * ACC_CYC;           // room for all accesses plus the flush

    logic             CLK, nRST;
    logic             dmemREN, dmemWEN, halt, dhit, flushed, cctrans;
    logic             snoop_req, snoop_inv, snoop_hit;
    cache_pkg::word_t dmemaddr, dmemstore, dmemload;
    cache_pkg::word_t snoop_addr, snoop_data, fetch_addr, fetch_data;

    // reference cache and memory image
    logic                 m_valid [`DC_SETS][`DC_WAYS];
    logic                 m_dirty [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_W-1:0] m_tag   [`DC_SETS][`DC_WAYS];
    cache_pkg::word_t     m_data  [`DC_SETS][`DC_WAYS][`DC_BLK_WORDS];
    logic                 m_lru   [`DC_SETS];
    cache_pkg::word_t     mem_img [`MEM_WORDS];
    int                   m_hits;

    cache_pkg::word_t exp_load, exp_snp_data, exp_fetch;
    logic             exp_snp_hit, fetch_chk, hit_taken;
    cache_pkg::word_t written [$];  // every address stored to
    int               errors, tests_failed, cycles;

    cache_top dut_i (
        .CLK(CLK), .nRST(nRST),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore),
        .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
        .snoop_req(snoop_req), .snoop_inv(snoop_inv), .snoop_addr(snoop_addr),
        .snoop_hit(snoop_hit), .snoop_data(snoop_data), .cctrans(cctrans),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data)
    );

    always #20 CLK = ~CLK;

    // dhit as seen by the rising edge, read back on the falling edge
    always @(posedge CLK or negedge nRST) begin
        if (!nRST)
            hit_taken <= 1'b0;
        else
            hit_taken <= dhit;
    end

    chk_load: assert property (@(posedge CLK) disable iff (!nRST)
        dhit && dmemREN |-> dmemload == exp_load)
        else begin
            errors++;
            $display("Mismatch dmemload: got %h, expected %h", $sampled(dmemload), exp_load);
        end
    // the bus sees a pulse on each accepted store
    chk_cctrans: assert property (@(posedge CLK) disable iff (!nRST)
        cctrans == (dhit && dmemWEN))
        else begin
            errors++;
            $display("Mismatch cctrans: got %h, expected %h",
                     $sampled(cctrans), $sampled(dhit && dmemWEN));
        end
    chk_snoop_hit: assert property (@(posedge CLK) disable iff (!nRST)
        snoop_req |-> ##2 snoop_hit == exp_snp_hit)
        else begin
            errors++;
            $display("Mismatch snoop_hit: got %h, expected %h", $sampled(snoop_hit), exp_snp_hit);
        end
    chk_snoop_data: assert property (@(posedge CLK) disable iff (!nRST)
        snoop_req && exp_snp_hit |-> ##2 snoop_data == exp_snp_data)
        else begin
            errors++;
            $display("Mismatch snoop_data: got %h, expected %h",
                     $sampled(snoop_data), exp_snp_data);
        end
    chk_fetch: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_chk |=> fetch_data == exp_fetch)
        else begin
            errors++;
            $display("Mismatch fetch_data at %h: got %h, expected %h",
                     fetch_addr, $sampled(fetch_data), exp_fetch);
        end

    function automatic logic [AW-1:0] word_idx(input cache_pkg::word_t a);
        return a[AW+1:2];
    endfunction

    function automatic cache_pkg::word_t frame_addr(input int s, input int w, input int b);
        return {m_tag[s][w], IDX_W'(s), 1'(b), 2'b00};
    endfunction

    function automatic int find_way(input cache_pkg::word_t a);
        cache_pkg::dcache_addr_t f;
        f = a;
        for (int w = 0; w < `DC_WAYS; w++)
            if (m_valid[f.idx][w] && m_tag[f.idx][w] == f.tag)
                return w;
        return -1;
    endfunction

    function automatic cache_pkg::word_t next_addr(input int span);
        return cache_pkg::word_t'($urandom % span) << 2;  // word aligned, below span words
    endfunction

    task automatic predict_access(input cache_pkg::word_t a, input logic wr,
                                  input cache_pkg::word_t wd);
        cache_pkg::dcache_addr_t f;
        int w;
        f = a;
        w = find_way(a);
        if (w < 0) begin
            // empty way first, else the LRU one
            w = !m_valid[f.idx][0] ? 0 : (!m_valid[f.idx][1] ? 1 : int'(m_lru[f.idx]));
            if (m_valid[f.idx][w] && m_dirty[f.idx][w])
                for (int b = 0; b < `DC_BLK_WORDS; b++)
                    mem_img[word_idx(frame_addr(f.idx, w, b))] = m_data[f.idx][w][b];
            m_tag[f.idx][w]   = f.tag;
            m_valid[f.idx][w] = 1'b1;
            m_dirty[f.idx][w] = 1'b0;
            for (int b = 0; b < `DC_BLK_WORDS; b++)
                m_data[f.idx][w][b] = mem_img[word_idx(frame_addr(f.idx, w, b))];
        end else if (!wr) begin
            m_hits++;  // the read right after a refill is not counted
        end
        m_lru[f.idx] = (w == 0);
        if (wr) begin
            m_data[f.idx][w][f.blkoff] = wd;
            m_dirty[f.idx][w] = 1'b1;
        end else begin
            exp_load = m_data[f.idx][w][f.blkoff];
        end
    endtask

    task automatic predict_snoop(input cache_pkg::word_t a, input logic inv);
        cache_pkg::dcache_addr_t f;
        int w;
        f = a;
        w = find_way(a);
        exp_snp_hit  = (w >= 0);
        exp_snp_data = '0;
        if (w >= 0) begin
            exp_snp_data = m_data[f.idx][w][f.blkoff];
            if (inv)
                m_valid[f.idx][w] = 1'b0;
            else
                m_dirty[f.idx][w] = 1'b0;  // the other cache now owns the data
        end
    endtask

    task automatic predict_flush();
        for (int s = 0; s < `DC_SETS; s++)
            for (int w = 0; w < `DC_WAYS; w++)
                if (m_valid[s][w] && m_dirty[s][w]) begin
                    for (int b = 0; b < `DC_BLK_WORDS; b++)
                        mem_img[word_idx(frame_addr(s, w, b))] = m_data[s][w][b];
                    m_dirty[s][w] = 1'b0;
                end
        mem_img[word_idx(`HIT_CNT_ADDR)] = m_hits;
    endtask

    task automatic cache_access(input cache_pkg::word_t a, input logic wr,
                                input cache_pkg::word_t wd);
        @(negedge CLK);
        predict_access(a, wr, wd);
        dmemaddr  = a;
        dmemstore = wd;
        dmemREN   = !wr;
        dmemWEN   = wr;
        do @(negedge CLK); while (!hit_taken);  // held until an edge sees dhit
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        if (wr)
            written.push_back(a);
    endtask

    task automatic snoop_line(input cache_pkg::word_t a, input logic inv);
        @(negedge CLK);
        predict_snoop(a, inv);
        snoop_addr = a;
        snoop_inv  = inv;
        snoop_req  = 1'b1;
        @(negedge CLK);
        snoop_req = 1'b0;
        repeat (2) @(negedge CLK);  // answer lands two edges after the request
    endtask

    task automatic check_fetch(input cache_pkg::word_t a);
        @(negedge CLK);
        fetch_addr = a;
        exp_fetch  = mem_img[word_idx(a)];
        fetch_chk  = 1'b1;
        @(negedge CLK);
        fetch_chk = 1'b0;
        @(negedge CLK);
    endtask

    task automatic end_test(input string name, input int err_at_start);
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_at_start);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        cache_pkg::word_t a, b, v;
        int e0;
        void'($urandom(32'hdbf20d3f));
        CLK = 1'b0;
        nRST = 1'b0;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        halt = 1'b0;
        dmemaddr = '0;
        dmemstore = '0;
        snoop_req = 1'b0;
        snoop_inv = 1'b0;
        snoop_addr = '0;
        fetch_addr = '0;
        fetch_chk = 1'b0;
        exp_load = '0;
        exp_snp_hit = 1'b0;
        exp_snp_data = '0;
        exp_fetch = '0;
        errors = 0;
        tests_failed = 0;
        m_hits = 0;
        for (int s = 0; s < `DC_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < `MEM_WORDS; i++)
            mem_img[i] = cache_pkg::word_t'(i * 4);
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            a = next_addr(3072);  // stays clear of the hit count word
            cache_access(a, 1'b0, '0);
            cache_access(a, 1'b0, '0);
        end
        end_test("read miss then hit", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = next_addr(3072);
            v = $urandom;
            cache_access(a, 1'b0, '0);
            cache_access(a, 1'b1, v);
            cache_access(a, 1'b0, '0);
            check_fetch(a);  // memory not updated yet
        end
        end_test("write hit", e0);

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            a = next_addr(2048);
            v = $urandom;
            cache_access(a, 1'b1, v);
            cache_access(a + 32'h400, 1'b0, '0);  // same index, other tags
            cache_access(a + 32'h800, 1'b0, '0);
            check_fetch(a);
        end
        end_test("dirty eviction", e0);

        e0 = errors;
        a = next_addr(3072);
        v = $urandom;
        cache_access(a, 1'b0, '0);
        cache_access(a, 1'b1, v);
        snoop_line(a, 1'b0);
        b = next_addr(3072);
        while (find_way(b) >= 0)
            b = next_addr(3072);
        snoop_line(b, 1'b0);
        snoop_line(a, 1'b1);
        cache_access(a, 1'b0, '0);
        end_test("snoop", e0);

        e0 = errors;
        @(negedge CLK);
        halt = 1'b1;
        predict_flush();
        while (!flushed)
            @(negedge CLK);
        foreach (written[i])
            check_fetch(written[i]);
        check_fetch(`HIT_CNT_ADDR);
        end_test("halt flush", e0);

        $display("tests: 5, failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
cache_pkg.sv
dcache.sv
mem_ctrl.sv
word_ram.sv
cache_top.sv
tb_cache_top.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, then look for the fail message in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_cache_top \
    -o tb_cache_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cache_top > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
